/* hdl/qeciphy_defines.svh */
// QECIPHY link parameters.
// Training, timeout and buffer sizing shared by the PHY blocks.

`ifndef QECIPHY_DEFINES_SVH
`define QECIPHY_DEFINES_SVH

// Consecutive good control words needed to leave training.
`define QECIPHY_TRAIN_COUNT 8

// Cycles allowed in training before the link faults.
`define QECIPHY_TRAIN_TIMEOUT 256

// Cycles spent in fault before retraining.
`define QECIPHY_FAULT_HOLD 32

// Receive buffer entries.
`define QECIPHY_RX_DEPTH 4

// Link timer width, wide enough for the training timeout.
`define QECIPHY_TIMER_W 9

`endif

/* hdl/qeciphy_lane_pkg.sv */
// QECIPHY lane format.
// 66-bit lane word: 2-bit sync header and a 64-bit data or control payload.

package qeciphy_lane_pkg;

   // Sync header codes.
   // 00 and 11 are illegal on the lane.
   typedef logic [1:0] sync_t;

   localparam sync_t SYNC_DATA = 2'b01;
   localparam sync_t SYNC_CTRL = 2'b10;

   // Control word types.
   typedef enum logic [7:0] {
      CTRL_IDLE  = 8'h1e,
      CTRL_TRAIN = 8'h4b
   } ctrl_type_e;

   // Fixed marker carried by every control word.
   // A wrong marker means the word is not a valid control word.
   localparam logic [55:0] QECIPHY_CTRL_MARK = 56'h5a_c3_96_3c_a5_0f_e1;

   // Control payload layout.
   typedef struct packed {
      ctrl_type_e  ctype;
      logic [55:0] mark;
   } ctrl_word_t;

   // One payload, two readings.
   // Raw data under SYNC_DATA, control word under SYNC_CTRL.
   typedef union packed {
      logic [63:0] data;
      ctrl_word_t  ctrl;
   } payload_u;

   // Full lane word, header in the top two bits.
   typedef struct packed {
      sync_t    header;
      payload_u payload;
   } lane_word_t;

endpackage

/* hdl/qeciphy_status_pkg.sv */
// QECIPHY link status types.
// Link state, error codes and receive events for the link FSM.

package qeciphy_status_pkg;

   // Link state, also the external status code.
   typedef enum logic [3:0] {
      LINK_RESET = 4'd0,
      LINK_TRAIN = 4'd1,
      LINK_READY = 4'd2,
      LINK_FAULT = 4'd3
   } link_state_e;

   // Error code, holds the last fault until the link is ready again.
   typedef enum logic [3:0] {
      ERR_NONE          = 4'd0,
      ERR_TRAIN_TIMEOUT = 4'd1,
      ERR_BAD_HEADER    = 4'd2,
      ERR_RX_OVERFLOW   = 4'd3
   } ecode_e;

   // Per-cycle receive flags from the deframer.
   typedef struct packed {
      logic good_ctrl;
      logic bad_header;
      logic overflow;
   } rx_event_t;

endpackage

/* hdl/qeciphy_link_timer.sv */
// QECIPHY link timer.
// Saturating cycle counter, restarted by the link FSM on each state entry.

`timescale 1ns/1ps
`include "qeciphy_defines.svh"

module qeciphy_link_timer (
   input  logic                        i_aclk,
   input  logic                        i_rst,
   input  logic                        i_start,
   output logic [`QECIPHY_TIMER_W-1:0] o_count
);

   logic [`QECIPHY_TIMER_W-1:0] count_q;
   logic                        at_max;

   // Counter stops at all ones.
   assign at_max = (count_q == '1);

   always_ff @(posedge i_aclk) begin
      if (i_rst) begin
         count_q <= '0;
      end else if (i_start) begin
         // Start wins over saturation.
         count_q <= '0;
      end else if (!at_max) begin
         count_q <= count_q + 1'b1;
      end
   end

   assign o_count = count_q;

   // Once saturated, the count only leaves the maximum through a restart.
   a_no_wrap: assert property (@(posedge i_aclk) disable iff (i_rst)
      (at_max && !i_start) |=> (count_q == '1));

endmodule

/* hdl/qeciphy_link_fsm.sv */
// QECIPHY link FSM.
// Trains the link, watches for receive faults and holds the error code.

`timescale 1ns/1ps
`include "qeciphy_defines.svh"

module qeciphy_link_fsm (
   input  logic                                i_aclk,
   input  logic                                i_rst,
   input  qeciphy_status_pkg::rx_event_t       i_rx_event,
   input  logic [`QECIPHY_TIMER_W-1:0]         i_timer_count,
   output logic                                o_timer_start,
   output qeciphy_status_pkg::link_state_e     o_state,
   output qeciphy_status_pkg::ecode_e          o_ecode
);

   localparam int TW    = `QECIPHY_TIMER_W;
   localparam int RUN_W = $clog2(`QECIPHY_TRAIN_COUNT + 1);

   // Last cycle of training and of fault hold, counted from state entry.
   localparam logic [TW-1:0]    TRAIN_LAST = TW'(`QECIPHY_TRAIN_TIMEOUT - 1);
   localparam logic [TW-1:0]    HOLD_LAST  = TW'(`QECIPHY_FAULT_HOLD - 1);
   localparam logic [RUN_W-1:0] RUN_LAST   = RUN_W'(`QECIPHY_TRAIN_COUNT - 1);

   qeciphy_status_pkg::link_state_e state_q, state_d;
   qeciphy_status_pkg::ecode_e      ecode_q, ecode_d;
   logic [RUN_W-1:0]                run_q, run_d;

   always_comb begin
      state_d = state_q;
      ecode_d = ecode_q;
      run_d   = run_q;
      case (state_q)
         // Leave reset one cycle after it is released.
         qeciphy_status_pkg::LINK_RESET: begin
            state_d = qeciphy_status_pkg::LINK_TRAIN;
            run_d   = '0;
         end
         // Count consecutive good control words.
         // Any other word restarts the run.
         qeciphy_status_pkg::LINK_TRAIN: begin
            if (i_rx_event.good_ctrl) begin
               run_d = run_q + 1'b1;
            end else begin
               run_d = '0;
            end
            if (i_rx_event.good_ctrl && run_q == RUN_LAST) begin
               state_d = qeciphy_status_pkg::LINK_READY;
               ecode_d = qeciphy_status_pkg::ERR_NONE;
               run_d   = '0;
            end else if (i_timer_count >= TRAIN_LAST) begin
               state_d = qeciphy_status_pkg::LINK_FAULT;
               ecode_d = qeciphy_status_pkg::ERR_TRAIN_TIMEOUT;
            end
         end
         // Header errors take priority over overflow.
         qeciphy_status_pkg::LINK_READY: begin
            if (i_rx_event.bad_header) begin
               state_d = qeciphy_status_pkg::LINK_FAULT;
               ecode_d = qeciphy_status_pkg::ERR_BAD_HEADER;
            end else if (i_rx_event.overflow) begin
               state_d = qeciphy_status_pkg::LINK_FAULT;
               ecode_d = qeciphy_status_pkg::ERR_RX_OVERFLOW;
            end
         end
         // Hold, then retrain with the error code kept.
         qeciphy_status_pkg::LINK_FAULT: begin
            run_d = '0;
            if (i_timer_count >= HOLD_LAST) begin
               state_d = qeciphy_status_pkg::LINK_TRAIN;
            end
         end
         default: begin
            state_d = qeciphy_status_pkg::LINK_RESET;
         end
      endcase
   end

   always_ff @(posedge i_aclk) begin
      if (i_rst) begin
         state_q <= qeciphy_status_pkg::LINK_RESET;
         ecode_q <= qeciphy_status_pkg::ERR_NONE;
         run_q   <= '0;
      end else begin
         state_q <= state_d;
         ecode_q <= ecode_d;
         run_q   <= run_d;
      end
   end

   // Timer restarts on every state change.
   assign o_timer_start = (state_d != state_q);
   assign o_state       = state_q;
   assign o_ecode       = ecode_q;

   // Only the four link states are ever held.
   a_state_legal: assert property (@(posedge i_aclk) disable iff (i_rst)
      state_q inside {qeciphy_status_pkg::LINK_RESET, qeciphy_status_pkg::LINK_TRAIN,
                      qeciphy_status_pkg::LINK_READY, qeciphy_status_pkg::LINK_FAULT});

   // A ready link never reports an error.
   a_ready_clean: assert property (@(posedge i_aclk) disable iff (i_rst)
      (state_q == qeciphy_status_pkg::LINK_READY) |-> (ecode_q == qeciphy_status_pkg::ERR_NONE));

endmodule

/* hdl/qeciphy_tx_framer.sv */
// QECIPHY transmit framer.
// Turns stream words or link control into registered 66-bit lane words.

`timescale 1ns/1ps

module qeciphy_tx_framer (
   input  logic                            i_aclk,
   input  logic                            i_rst,
   input  qeciphy_status_pkg::link_state_e i_state,
   input  logic [63:0]                     i_tx_tdata,
   input  logic                            i_tx_tvalid,
   output logic                            o_tx_tready,
   output qeciphy_lane_pkg::lane_word_t    o_lane_tx
);

   qeciphy_lane_pkg::lane_word_t lane_d;
   logic                         tx_fire;

   // Data is accepted only on a trained link.
   assign o_tx_tready = (i_state == qeciphy_status_pkg::LINK_READY);
   assign tx_fire     = i_tx_tvalid && o_tx_tready;

   always_comb begin
      lane_d = '0;
      if (tx_fire) begin
         lane_d.header       = qeciphy_lane_pkg::SYNC_DATA;
         lane_d.payload.data = i_tx_tdata;
      end else begin
         // TRAIN words while training, IDLE in every other state.
         lane_d.header            = qeciphy_lane_pkg::SYNC_CTRL;
         lane_d.payload.ctrl.mark = qeciphy_lane_pkg::QECIPHY_CTRL_MARK;
         if (i_state == qeciphy_status_pkg::LINK_TRAIN) begin
            lane_d.payload.ctrl.ctype = qeciphy_lane_pkg::CTRL_TRAIN;
         end else begin
            lane_d.payload.ctrl.ctype = qeciphy_lane_pkg::CTRL_IDLE;
         end
      end
   end

   // All zeros in reset.
   // Header 00 is illegal, so a peer cannot train against a PHY held in reset.
   always_ff @(posedge i_aclk) begin
      if (i_rst) begin
         o_lane_tx <= '0;
      end else begin
         o_lane_tx <= lane_d;
      end
   end

   // A data header goes out only for a word accepted while ready.
   a_data_when_ready: assert property (@(posedge i_aclk) disable iff (i_rst)
      (o_lane_tx.header == qeciphy_lane_pkg::SYNC_DATA)
         |-> $past(i_state == qeciphy_status_pkg::LINK_READY));

endmodule

/* hdl/qeciphy_rx_deframer.sv */
// QECIPHY receive deframer.
// Checks lane headers and control markers, buffers data for the receive stream.

`timescale 1ns/1ps
`include "qeciphy_defines.svh"

module qeciphy_rx_deframer (
   input  logic                            i_aclk,
   input  logic                            i_rst,
   input  qeciphy_status_pkg::link_state_e i_state,
   input  qeciphy_lane_pkg::lane_word_t    i_lane_rx,
   output logic [63:0]                     o_rx_tdata,
   output logic                            o_rx_tvalid,
   input  logic                            i_rx_tready,
   output qeciphy_status_pkg::rx_event_t   o_rx_event
);

   localparam int DEPTH = `QECIPHY_RX_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   qeciphy_lane_pkg::lane_word_t lane_q;
   logic [63:0]                  mem [DEPTH];
   logic [PTR_W-1:0]             wr_ptr_q;
   logic [PTR_W-1:0]             rd_ptr_q;
   logic [CNT_W-1:0]             count_q;
   logic                         is_ready;
   logic                         is_data;
   logic                         is_ctrl;
   logic                         room;
   logic                         push;
   logic                         pop;
   logic                         flush;

   // Lane input register, cleared to an illegal header.
   always_ff @(posedge i_aclk) begin
      if (i_rst) begin
         lane_q <= '0;
      end else begin
         lane_q <= i_lane_rx;
      end
   end

   // Header decode.
   assign is_ready = (i_state == qeciphy_status_pkg::LINK_READY);
   assign is_data  = (lane_q.header == qeciphy_lane_pkg::SYNC_DATA);
   assign is_ctrl  = (lane_q.header == qeciphy_lane_pkg::SYNC_CTRL);
   assign flush    = (i_state == qeciphy_status_pkg::LINK_FAULT);

   // A full buffer still takes a word if one leaves in the same cycle.
   assign pop  = o_rx_tvalid && i_rx_tready;
   assign room = (count_q != CNT_W'(DEPTH)) || pop;
   assign push = is_ready && is_data && room;

   // Events for the link FSM.
   always_comb begin
      o_rx_event.good_ctrl  = is_ctrl &&
                              (lane_q.payload.ctrl.mark == qeciphy_lane_pkg::QECIPHY_CTRL_MARK);
      o_rx_event.bad_header = is_ready && !is_data && !is_ctrl;
      // The overflowing word is dropped.
      o_rx_event.overflow   = is_ready && is_data && !room;
   end

   // Buffer storage.
   always_ff @(posedge i_aclk) begin
      if (push) begin
         mem[wr_ptr_q] <= lane_q.payload.data;
      end
   end

   // Pointers and fill count, emptied while the link is in fault.
   always_ff @(posedge i_aclk) begin
      if (i_rst) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else if (flush) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         if (push && !pop) begin
            count_q <= count_q + 1'b1;
         end else if (pop && !push) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   // Head of buffer drives the stream.
   assign o_rx_tdata  = mem[rd_ptr_q];
   assign o_rx_tvalid = (count_q != '0);

   // Fill count stays within the buffer.
   a_count_bound: assert property (@(posedge i_aclk) disable iff (i_rst)
      count_q <= CNT_W'(DEPTH));

endmodule

/* hdl/qeciphy.sv */
// QECIPHY top level.
// Link FSM, timer, framer and deframer on one clock.

`timescale 1ns/1ps
`include "qeciphy_defines.svh"

module qeciphy (
   input  logic                            i_aclk,
   input  logic                            i_rst,
   input  logic [63:0]                     i_tx_tdata,
   input  logic                            i_tx_tvalid,
   output logic                            o_tx_tready,
   output logic [63:0]                     o_rx_tdata,
   output logic                            o_rx_tvalid,
   input  logic                            i_rx_tready,
   output qeciphy_lane_pkg::lane_word_t    o_lane_tx,
   input  qeciphy_lane_pkg::lane_word_t    i_lane_rx,
   output qeciphy_status_pkg::link_state_e o_status,
   output qeciphy_status_pkg::ecode_e      o_ecode
);

   logic                          timer_start;
   logic [`QECIPHY_TIMER_W-1:0]   timer_count;
   qeciphy_status_pkg::rx_event_t rx_event;

   qeciphy_link_timer u_link_timer (
      .i_aclk  (i_aclk),
      .i_rst   (i_rst),
      .i_start (timer_start),
      .o_count (timer_count)
   );

   // Status output doubles as the state bus to both data blocks.
   qeciphy_link_fsm u_link_fsm (
      .i_aclk        (i_aclk),
      .i_rst         (i_rst),
      .i_rx_event    (rx_event),
      .i_timer_count (timer_count),
      .o_timer_start (timer_start),
      .o_state       (o_status),
      .o_ecode       (o_ecode)
   );

   qeciphy_tx_framer u_tx_framer (
      .i_aclk      (i_aclk),
      .i_rst       (i_rst),
      .i_state     (o_status),
      .i_tx_tdata  (i_tx_tdata),
      .i_tx_tvalid (i_tx_tvalid),
      .o_tx_tready (o_tx_tready),
      .o_lane_tx   (o_lane_tx)
   );

   qeciphy_rx_deframer u_rx_deframer (
      .i_aclk      (i_aclk),
      .i_rst       (i_rst),
      .i_state     (o_status),
      .i_lane_rx   (i_lane_rx),
      .o_rx_tdata  (o_rx_tdata),
      .o_rx_tvalid (o_rx_tvalid),
      .i_rx_tready (i_rx_tready),
      .o_rx_event  (rx_event)
   );

endmodule

/* tb/qeciphy_tb.sv */
// QECIPHY testbench.
// Two PHYs back to back with a lane fault injector, checked against a model queue of sent words.

`timescale 1ns/1ps
`include "qeciphy_defines.svh"

module qeciphy_tb;

   localparam int CLK_PERIOD  = 8;
   localparam int NUM_VEC     = 13;
   localparam int SEND_LIMIT  = 16;
   localparam int DRAIN_LIM   = 16;
   localparam int PRESENT_LIM = 4;

   // Cycle budget of each test.
   // The watchdog allows twice the total.
   localparam int B1 = 16 + `QECIPHY_TRAIN_COUNT + 8;
   localparam int B2 = 6 * 4 + 24;
   localparam int B3 = 6 * (`QECIPHY_RX_DEPTH + 2) + 24;
   localparam int B4 = `QECIPHY_FAULT_HOLD + `QECIPHY_TRAIN_TIMEOUT + 32;
   localparam int B5 = 2 * `QECIPHY_RX_DEPTH + 16;
   localparam int B6 = 2 * (`QECIPHY_FAULT_HOLD + `QECIPHY_TRAIN_TIMEOUT) + 32;
   localparam int WATCHDOG_NS = 2 * (B1 + B2 + B3 + B4 + B5 + B6) * CLK_PERIOD;

   // One stimulus entry.
   // Stall set means peer0 back-pressures once this word reaches it.
   typedef struct packed {
      logic [63:0] data;
      logic        stall;
   } vec_t;

   localparam vec_t VECTORS [NUM_VEC] = '{
      '{64'h0123_4567_89ab_cdef, 1'b0},
      '{64'hfedc_ba98_7654_3210, 1'b0},
      '{64'h0000_0000_0000_0000, 1'b0},
      '{64'hffff_ffff_ffff_ffff, 1'b0},
      '{64'h5a5a_a5a5_3c3c_c3c3, 1'b0},
      '{64'h1e1e_4b4b_0f0f_e1e1, 1'b0},
      '{64'hdead_beef_cafe_f00d, 1'b1},
      '{64'h8000_0000_0000_0001, 1'b1},
      '{64'h0102_0408_1020_4080, 1'b1},
      '{64'h7fff_ffff_ffff_fffe, 1'b1},
      '{64'h1357_9bdf_2468_ace0, 1'b1},
      '{64'haaaa_5555_aaaa_5555, 1'b1},
      '{64'h0bad_c0de_0dd_f00d0, 1'b0}
   };

   logic                            clk;
   logic                            rst;
   logic                            peer_rst;
   logic                            inject;
   logic [63:0]                     dut_tx_tdata;
   logic                            dut_tx_tvalid;
   logic                            dut_tx_tready;
   logic [63:0]                     dut_rx_tdata;
   logic                            dut_rx_tvalid;
   logic                            dut_rx_tready;
   logic [63:0]                     peer_tx_tdata;
   logic                            peer_tx_tvalid;
   logic                            peer_tx_tready;
   logic [63:0]                     peer_rx_tdata;
   logic                            peer_rx_tvalid;
   logic                            peer_rx_tready;
   qeciphy_lane_pkg::lane_word_t    dut_lane_tx;
   qeciphy_lane_pkg::lane_word_t    peer_lane_rx;
   qeciphy_lane_pkg::lane_word_t    peer_lane_tx;
   qeciphy_status_pkg::link_state_e dut_status;
   qeciphy_status_pkg::link_state_e peer_status;
   qeciphy_status_pkg::ecode_e      dut_ecode;
   qeciphy_status_pkg::ecode_e      peer_ecode;

   // Words accepted by dut0, in the order peer0 must deliver them.
   logic [63:0] sent_q [$];
   integer      seed;
   int          err_count;
   int          test_errs;
   int          tests_run;
   int          tests_failed;

   qeciphy dut0 (
      .i_aclk (clk), .i_rst (rst),
      .i_tx_tdata (dut_tx_tdata), .i_tx_tvalid (dut_tx_tvalid), .o_tx_tready (dut_tx_tready),
      .o_rx_tdata (dut_rx_tdata), .o_rx_tvalid (dut_rx_tvalid), .i_rx_tready (dut_rx_tready),
      .o_lane_tx (dut_lane_tx), .i_lane_rx (peer_lane_tx),
      .o_status (dut_status), .o_ecode (dut_ecode)
   );

   qeciphy peer0 (
      .i_aclk (clk), .i_rst (peer_rst),
      .i_tx_tdata (peer_tx_tdata), .i_tx_tvalid (peer_tx_tvalid), .o_tx_tready (peer_tx_tready),
      .o_rx_tdata (peer_rx_tdata), .o_rx_tvalid (peer_rx_tvalid), .i_rx_tready (peer_rx_tready),
      .o_lane_tx (peer_lane_tx), .i_lane_rx (peer_lane_rx),
      .o_status (peer_status), .o_ecode (peer_ecode)
   );

   // Fault injector.
   // Forces an illegal 00 header on request.
   always_comb begin
      peer_lane_rx = dut_lane_tx;
      if (inject) begin
         peer_lane_rx.header = 2'b00;
      end
   end

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Ends a run that stops making progress.
   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired, the tests did not finish in time");
      $display("Done: errors found");
      $finish;
   end

   task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp) else begin
         err_count++;
         $display("Fail at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic confirm(input logic cond, input string what);
      assert (cond) else begin
         err_count++;
         $display("Error at %0t: %s", $time, what);
      end
   endtask

   // One clock cycle.
   // Transfers are taken from the values that the coming edge sees.
   task automatic step();
      logic        tx_fire;
      logic        rx_fire;
      logic [63:0] tx_word;
      logic [63:0] rx_word;
      logic [63:0] exp_word;
      tx_fire = dut_tx_tvalid && dut_tx_tready;
      rx_fire = peer_rx_tvalid && peer_rx_tready;
      tx_word = dut_tx_tdata;
      rx_word = peer_rx_tdata;
      @(posedge clk);
      #1;
      if (tx_fire) begin
         sent_q.push_back(tx_word);
      end
      if (rx_fire) begin
         confirm(sent_q.size() > 0, "peer0 delivered a word that dut0 never sent");
         if (sent_q.size() > 0) begin
            exp_word = sent_q.pop_front();
            check_eq("peer0.o_rx_tdata", rx_word, exp_word);
         end
      end
   endtask

   task automatic send_word(input logic [63:0] data);
      int waited;
      waited        = 0;
      dut_tx_tdata  = data;
      dut_tx_tvalid = 1'b1;
      while (!dut_tx_tready && waited < SEND_LIMIT) begin
         step();
         waited++;
      end
      confirm(dut_tx_tready, "dut0 never accepted a transmit word");
      step();
      dut_tx_tvalid = 1'b0;
   endtask

   task automatic wait_status(input bit on_peer, input qeciphy_status_pkg::link_state_e want,
                              input int limit, input string what);
      int waited;
      waited = 0;
      while ((on_peer ? peer_status : dut_status) != want && waited < limit) begin
         step();
         waited++;
      end
      confirm((on_peer ? peer_status : dut_status) == want, {"timed out waiting for ", what});
   endtask

   // Waits until every sent word is delivered, then watches for extra words.
   task automatic drain();
      int waited;
      waited = 0;
      while (sent_q.size() > 0 && waited < DRAIN_LIM) begin
         step();
         waited++;
      end
      confirm(sent_q.size() == 0, "sent words were lost before reaching peer0");
      repeat (4) step();
   endtask

   task automatic apply_range(input int first, input int last);
      int stall_len;
      int waited;
      for (int i = first; i <= last; i++) begin
         send_word(VECTORS[i].data);
         if (VECTORS[i].stall) begin
            // Hold the word at peer0's output for 1 to RX_DEPTH-1 cycles.
            stall_len = 1 + int'($unsigned($random(seed)) % (`QECIPHY_RX_DEPTH - 1));
            waited    = 0;
            while (!peer_rx_tvalid && waited < PRESENT_LIM) begin
               step();
               waited++;
            end
            confirm(peer_rx_tvalid, "peer0 never presented the stalled word");
            peer_rx_tready = 1'b0;
            repeat (stall_len) step();
            peer_rx_tready = 1'b1;
         end
      end
      drain();
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (err_count == test_errs) begin
         $display("Test %0d %s: pass", tests_run, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: failed", tests_run, name);
      end
      test_errs = err_count;
   endtask

   initial begin
      int waited;
      $timeformat(-9, 0, " ns", 0);
      seed           = 32'had0a;
      err_count      = 0;
      test_errs      = 0;
      tests_run      = 0;
      tests_failed   = 0;
      rst            = 1'b1;
      peer_rst       = 1'b1;
      inject         = 1'b0;
      dut_tx_tdata   = '0;
      dut_tx_tvalid  = 1'b0;
      dut_rx_tready  = 1'b1;
      peer_tx_tdata  = '0;
      peer_tx_tvalid = 1'b0;
      peer_rx_tready = 1'b1;

      // Test 1.
      // Quiet outputs in reset and one cycle after. Then the link comes up.
      for (int c = 0; c <= 16; c++) begin
         if (c < 16) begin
            step();
         end else begin
            rst      = 1'b0;
            peer_rst = 1'b0;
         end
         check_eq("dut0.o_status", 64'(dut_status), 64'(qeciphy_status_pkg::LINK_RESET));
         check_eq("peer0.o_status", 64'(peer_status), 64'(qeciphy_status_pkg::LINK_RESET));
         check_eq("dut0.o_tx_tready", 64'(dut_tx_tready), 64'd0);
         check_eq("peer0.o_tx_tready", 64'(peer_tx_tready), 64'd0);
         check_eq("dut0.o_rx_tvalid", 64'(dut_rx_tvalid), 64'd0);
         check_eq("peer0.o_rx_tvalid", 64'(peer_rx_tvalid), 64'd0);
      end
      waited = 0;
      while ((dut_status != qeciphy_status_pkg::LINK_READY ||
              peer_status != qeciphy_status_pkg::LINK_READY) &&
             waited < `QECIPHY_TRAIN_COUNT + 4) begin
         step();
         waited++;
      end
      confirm(dut_status == qeciphy_status_pkg::LINK_READY &&
              peer_status == qeciphy_status_pkg::LINK_READY,
              "link did not come up within TRAIN_COUNT+4 cycles");
      check_eq("dut0.o_ecode", 64'(dut_ecode), 64'(qeciphy_status_pkg::ERR_NONE));
      check_eq("peer0.o_ecode", 64'(peer_ecode), 64'(qeciphy_status_pkg::ERR_NONE));
      end_test("reset and link-up");

      // Test 2.
      apply_range(0, 5);
      end_test("data transfer");

      // Test 3.
      apply_range(6, 11);
      check_eq("peer0.o_status", 64'(peer_status), 64'(qeciphy_status_pkg::LINK_READY));
      check_eq("dut0.o_status", 64'(dut_status), 64'(qeciphy_status_pkg::LINK_READY));
      end_test("short stalls");

      // Test 4.
      // One bad header makes peer0 fault and retrain. One more word follows.
      inject = 1'b1;
      step();
      inject = 1'b0;
      wait_status(1'b1, qeciphy_status_pkg::LINK_FAULT, 4, "peer0 fault on bad header");
      check_eq("peer0.o_ecode", 64'(peer_ecode), 64'(qeciphy_status_pkg::ERR_BAD_HEADER));
      wait_status(1'b1, qeciphy_status_pkg::LINK_READY,
                  `QECIPHY_FAULT_HOLD + `QECIPHY_TRAIN_TIMEOUT, "peer0 to retrain");
      check_eq("peer0.o_ecode", 64'(peer_ecode), 64'(qeciphy_status_pkg::ERR_NONE));
      check_eq("dut0.o_status", 64'(dut_status), 64'(qeciphy_status_pkg::LINK_READY));
      apply_range(12, 12);
      end_test("header corruption");

      // Test 5.
      // One word more than the buffer holds.
      peer_rx_tready = 1'b0;
      for (int i = 0; i <= `QECIPHY_RX_DEPTH; i++) begin
         send_word(VECTORS[i].data);
      end
      wait_status(1'b1, qeciphy_status_pkg::LINK_FAULT, 8, "peer0 fault on overflow");
      check_eq("peer0.o_ecode", 64'(peer_ecode), 64'(qeciphy_status_pkg::ERR_RX_OVERFLOW));
      check_eq("dut0.o_status", 64'(dut_status), 64'(qeciphy_status_pkg::LINK_READY));
      // Buffered words are flushed by the fault.
      step();
      sent_q.delete();
      peer_rx_tready = 1'b1;
      end_test("receive overflow");

      // Test 6.
      // With peer0 silent, dut0 must time out in training and never come up.
      peer_rst = 1'b1;
      wait_status(1'b0, qeciphy_status_pkg::LINK_FAULT, 8, "dut0 to drop the link");
      waited = 0;
      while (dut_ecode != qeciphy_status_pkg::ERR_TRAIN_TIMEOUT &&
             waited < `QECIPHY_FAULT_HOLD + `QECIPHY_TRAIN_TIMEOUT + 8) begin
         step();
         waited++;
         confirm(dut_status != qeciphy_status_pkg::LINK_READY,
                 "dut0 reached LINK_READY with peer0 held in reset");
      end
      check_eq("dut0.o_status", 64'(dut_status), 64'(qeciphy_status_pkg::LINK_FAULT));
      check_eq("dut0.o_ecode", 64'(dut_ecode), 64'(qeciphy_status_pkg::ERR_TRAIN_TIMEOUT));
      peer_rst = 1'b0;
      wait_status(1'b0, qeciphy_status_pkg::LINK_READY,
                  `QECIPHY_FAULT_HOLD + `QECIPHY_TRAIN_TIMEOUT, "dut0 to retrain");
      wait_status(1'b1, qeciphy_status_pkg::LINK_READY,
                  `QECIPHY_TRAIN_COUNT + 4, "peer0 to train");
      check_eq("dut0.o_ecode", 64'(dut_ecode), 64'(qeciphy_status_pkg::ERR_NONE));
      check_eq("peer0.o_ecode", 64'(peer_ecode), 64'(qeciphy_status_pkg::ERR_NONE));
      end_test("training timeout");

      $display("Tests run: %0d, tests failed: %0d, errors: %0d",
               tests_run, tests_failed, err_count);
      if (err_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

/* verilog.f */
+incdir+hdl
hdl/qeciphy_lane_pkg.sv
hdl/qeciphy_status_pkg.sv
hdl/qeciphy_link_timer.sv
hdl/qeciphy_link_fsm.sv
hdl/qeciphy_tx_framer.sv
hdl/qeciphy_rx_deframer.sv
hdl/qeciphy.sv
tb/qeciphy_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the QECIPHY testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   -f verilog.f --top-module qeciphy_tb -o qeciphy_sim

./obj_dir/qeciphy_sim > sim.log
cat sim.log

if grep -q "Done: errors found" sim.log; then
   exit 1
fi
exit 0
